// ==== common/ct_pkg.sv ====
`default_nettype none

package ct_pkg;

    localparam int NUM_TIMERS = 2;

    typedef logic [31:0]           word_t;
    typedef logic [3:0]            byte_en_t;
    typedef logic [NUM_TIMERS-1:0] irq_vec_t;   // One line per timer

    // Block base and per-timer window
    localparam word_t CT_BASE_ADR     = 32'h2400_0000;
    localparam word_t CT_TIMER_STRIDE = 32'h100;

    localparam int CT_IDX_BIT    = $clog2(CT_TIMER_STRIDE);          // Timer select bit
    localparam int CT_WINDOW_LSB = CT_IDX_BIT + $clog2(NUM_TIMERS);  // Lowest base bit

    typedef logic [CT_IDX_BIT-1:0] reg_ofs_t;

    // Register offsets inside a timer window
    localparam reg_ofs_t CT_REG_CONFIG = 8'h00;
    localparam reg_ofs_t CT_REG_VALUE  = 8'h04;   // Reload value
    localparam reg_ofs_t CT_REG_DATA   = 8'h08;   // Current value

    typedef struct packed {
        logic irq_ena;
        logic chain;
        logic updown;    // 1 counts up
        logic oneshot;
        logic enable;
    } ct_cfg_t;

    typedef struct packed {
        word_t    adr;
        word_t    dat;
        byte_en_t sel;
        logic     we;
        logic     cyc;
        logic     stb;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== counter_timer/counter_timer.sv ====
`default_nettype none

module counter_timer (
    input  wire              clkin,
    input  wire              resetn,
    input  wire              strobe_i,
    input  wire              cfg_we_i,
    input  wire ct_pkg::byte_en_t val_we_i,
    input  wire ct_pkg::byte_en_t dat_we_i,
    input  wire ct_pkg::word_t    wdata_i,
    output ct_pkg::ct_cfg_t  cfg_o,
    output ct_pkg::word_t    reload_o,
    output ct_pkg::word_t    value_o,
    output logic             strobe_o,
    output logic             irq_o
);
    import ct_pkg::*;

    ct_cfg_t cfg_q;
    logic    last_enable_q;    // Catches the enable rising edge
    word_t   reload_q;
    word_t   value_q;
    logic    strobe_q;

    word_t   start_val;
    word_t   term_val;
    logic    step;

    // Per-lane merge of a register write
    function automatic word_t lane_merge(input word_t old_val,
                                         input word_t new_val,
                                         input byte_en_t lanes);
        word_t res;
        res = old_val;
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            if (lanes[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign start_val = cfg_q.updown ? '0 : reload_q;
    assign term_val  = cfg_q.updown ? reload_q : '0;
    assign step      = !cfg_q.chain || strobe_i;   // Chain gates on the strobe

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg_q         <= '0;
            last_enable_q <= 1'b0;
        end else begin
            last_enable_q <= cfg_q.enable;
            if (cfg_we_i) begin
                cfg_q <= ct_cfg_t'(wdata_i[$bits(ct_cfg_t)-1:0]);
            end
        end
    end

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            reload_q <= '0;
        end else if (val_we_i != '0) begin
            reload_q <= lane_merge(reload_q, wdata_i, val_we_i);
        end
    end

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_q  <= '0;
            strobe_q <= 1'b0;
        end else if (dat_we_i != '0) begin
            value_q  <= lane_merge(value_q, wdata_i, dat_we_i);   // Bus write wins
            strobe_q <= 1'b0;
        end else if (cfg_q.enable) begin
            if (!last_enable_q) begin
                value_q <= start_val;   // First enabled cycle
            end else if (value_q == term_val) begin
                if (!cfg_q.oneshot) begin
                    value_q <= start_val;
                end
                strobe_q <= 1'b1;
            end else if (step) begin
                if (cfg_q.updown) begin
                    value_q <= value_q + 32'd1;
                end else begin
                    value_q <= value_q - 32'd1;
                end
                strobe_q <= 1'b0;
            end
        end else begin
            strobe_q <= 1'b0;
        end
    end

    assign cfg_o    = cfg_q;
    assign reload_o = reload_q;
    assign value_o  = value_q;
    assign strobe_o = strobe_q;
    assign irq_o    = strobe_q & cfg_q.irq_ena;

endmodule

`default_nettype wire

// ==== counter_timer/counter_timer_wb.sv ====
`default_nettype none

module counter_timer_wb (
    input  wire ct_pkg::wb_req_t  wb_req_i,
    output ct_pkg::wb_rsp_t       wb_rsp_o,
    output logic                  cfg_we_o,
    output ct_pkg::byte_en_t      val_we_o,
    output ct_pkg::byte_en_t      dat_we_o,
    output ct_pkg::word_t         wdata_o,
    input  wire ct_pkg::ct_cfg_t  cfg_i,
    input  wire ct_pkg::word_t    reload_i,
    input  wire ct_pkg::word_t    value_i
);
    import ct_pkg::*;

    logic     valid;
    reg_ofs_t ofs;
    logic     cfg_sel;
    logic     val_sel;
    logic     dat_sel;
    logic     wr;

    // stb arrives already gated by the window decode
    assign valid = wb_req_i.cyc & wb_req_i.stb;
    assign ofs   = wb_req_i.adr[CT_IDX_BIT-1:0];
    assign wr    = wb_req_i.we;

    assign cfg_sel = valid && (ofs == CT_REG_CONFIG);
    assign val_sel = valid && (ofs == CT_REG_VALUE);
    assign dat_sel = valid && (ofs == CT_REG_DATA);

    assign cfg_we_o = cfg_sel & wr & wb_req_i.sel[0];   // Lane 0 only
    assign val_we_o = (val_sel && wr) ? wb_req_i.sel : '0;
    assign dat_we_o = (dat_sel && wr) ? wb_req_i.sel : '0;
    assign wdata_o  = wb_req_i.dat;

    always_comb begin
        wb_rsp_o.ack = cfg_sel | val_sel | dat_sel;
        if (cfg_sel) begin
            wb_rsp_o.dat = {{($bits(word_t) - $bits(ct_cfg_t)){1'b0}}, cfg_i};
        end else if (val_sel) begin
            wb_rsp_o.dat = reload_i;
        end else if (dat_sel) begin
            wb_rsp_o.dat = value_i;
        end else begin
            wb_rsp_o.dat = '0;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/ct_pkg.sv
counter_timer/counter_timer.sv
counter_timer/counter_timer_wb.sv
source/timer_bus_decode.sv
source/timer_subsys.sv
tb/timer_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the timer subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module timer_subsys_tb -o timer_subsys_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/timer_subsys_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q -x "all tests passed"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== source/timer_bus_decode.sv ====
`default_nettype none

module timer_bus_decode (
    input  wire ct_pkg::wb_req_t wb_req_i,
    output ct_pkg::wb_rsp_t      wb_rsp_o,
    output ct_pkg::wb_req_t      t0_req_o,
    output ct_pkg::wb_req_t      t1_req_o,
    input  wire ct_pkg::wb_rsp_t t0_rsp_i,
    input  wire ct_pkg::wb_rsp_t t1_rsp_i
);
    import ct_pkg::*;

    logic in_window;
    logic idx;

    // Upper bits must hit the block base
    assign in_window = (wb_req_i.adr[$bits(word_t)-1:CT_WINDOW_LSB] ==
                        CT_BASE_ADR[$bits(word_t)-1:CT_WINDOW_LSB]);
    assign idx       = wb_req_i.adr[CT_IDX_BIT];

    always_comb begin
        t0_req_o     = wb_req_i;
        t0_req_o.stb = wb_req_i.stb & in_window & ~idx;
        t1_req_o     = wb_req_i;
        t1_req_o.stb = wb_req_i.stb & in_window & idx;
    end

    assign wb_rsp_o.ack = t0_rsp_i.ack | t1_rsp_i.ack;
    assign wb_rsp_o.dat = idx ? t1_rsp_i.dat : t0_rsp_i.dat;

endmodule

`default_nettype wire

// ==== source/timer_subsys.sv ====
`default_nettype none

module timer_subsys (
    input  wire                    clkin,
    input  wire                    resetn,
    input  wire ct_pkg::wb_req_t   wb_req_i,
    output ct_pkg::wb_rsp_t        wb_rsp_o,
    input  wire                    ext_strobe_i,
    output wire ct_pkg::irq_vec_t  irq_o,
    output wire                    strobe_o
);
    import ct_pkg::*;

    wb_req_t  t_req    [NUM_TIMERS];
    wb_rsp_t  t_rsp    [NUM_TIMERS];
    logic     cfg_we   [NUM_TIMERS];
    byte_en_t val_we   [NUM_TIMERS];
    byte_en_t dat_we   [NUM_TIMERS];
    word_t    wdata    [NUM_TIMERS];
    ct_cfg_t  cfg      [NUM_TIMERS];
    word_t    reload   [NUM_TIMERS];
    word_t    value    [NUM_TIMERS];
    wire [NUM_TIMERS:0] strobe_chain;   // Timer i feeds timer i+1

    assign strobe_chain[0] = ext_strobe_i;
    assign strobe_o        = strobe_chain[NUM_TIMERS];

    timer_bus_decode timer_bus_decode_inst (
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .t0_req_o (t_req[0]),
        .t1_req_o (t_req[1]),
        .t0_rsp_i (t_rsp[0]),
        .t1_rsp_i (t_rsp[1])
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        counter_timer_wb counter_timer_wb_inst (
            .wb_req_i (t_req[i]),
            .wb_rsp_o (t_rsp[i]),
            .cfg_we_o (cfg_we[i]),
            .val_we_o (val_we[i]),
            .dat_we_o (dat_we[i]),
            .wdata_o  (wdata[i]),
            .cfg_i    (cfg[i]),
            .reload_i (reload[i]),
            .value_i  (value[i])
        );

        counter_timer counter_timer_inst (
            .clkin    (clkin),
            .resetn   (resetn),
            .strobe_i (strobe_chain[i]),
            .cfg_we_i (cfg_we[i]),
            .val_we_i (val_we[i]),
            .dat_we_i (dat_we[i]),
            .wdata_i  (wdata[i]),
            .cfg_o    (cfg[i]),
            .reload_o (reload[i]),
            .value_o  (value[i]),
            .strobe_o (strobe_chain[i+1]),
            .irq_o    (irq_o[i])
        );
    end

endmodule

`default_nettype wire

// ==== tb/timer_subsys_tb.sv ====
`default_nettype none

module timer_subsys_tb;
    import ct_pkg::*;

    localparam int BUS_TIMEOUT = 16;    // Cycles without ack
    localparam int IRQ_TIMEOUT = 400;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_MAX,    // Read must not exceed exp
        OP_NOACK,       // Read that must never be acked
        OP_IDLE,        // dat holds the cycle count
        OP_WAIT_IRQ
    } op_e;

    typedef struct packed {
        op_e      op;
        word_t    adr;
        word_t    dat;
        byte_en_t sel;
        word_t    exp;
        irq_vec_t irq;
        logic     strb;
    } entry_t;

    logic        clkin;
    logic        resetn;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        ext_strobe;
    irq_vec_t    irq;
    logic        strobe;

    entry_t      tbl [$];
    logic [15:0] lfsr_q;

    timer_subsys timer_subsys_inst (
        .clkin        (clkin),
        .resetn       (resetn),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .ext_strobe_i (ext_strobe),
        .irq_o        (irq),
        .strobe_o     (strobe)
    );

    initial begin
        clkin = 1'b0;
        forever #2 clkin = ~clkin;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output word_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};
        end
    endtask

    function automatic word_t reg_adr(input int tmr, input reg_ofs_t ofs);
        return CT_BASE_ADR + CT_TIMER_STRIDE * word_t'(tmr) + word_t'(ofs);
    endfunction

    // Field order irq_ena, chain, updown, oneshot, enable
    function automatic word_t cfg_word(input logic irq_ena, input logic chain,
                                       input logic updown, input logic oneshot,
                                       input logic enable);
        return {27'd0, irq_ena, chain, updown, oneshot, enable};
    endfunction

    function automatic word_t byte_merge(input word_t old_val, input word_t new_val,
                                         input byte_en_t sel);
        word_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t want, input word_t got);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, want, got);
            abort_run();
        end
    endtask

    task automatic check_word_max(input string name, input word_t limit, input word_t got);
        if (got > limit) begin
            $display("[ERROR] t=%0t %s expected <= %h got %h", $time, name, limit, got);
            abort_run();
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t want, input irq_vec_t got);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, want, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, want, got);
            abort_run();
        end
    endtask

    // One classic Wishbone cycle, ack sampled mid-cycle
    task automatic bus_cycle(input logic we, input word_t adr, input word_t dat,
                             input byte_en_t sel, output word_t rdata, output logic acked);
        int n;
        n      = 0;
        acked  = 1'b0;
        rdata  = '0;
        @(posedge clkin);
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        wb_req.sel <= sel;
        wb_req.we  <= we;
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        @(negedge clkin);
        while (wb_rsp.ack !== 1'b1 && n < BUS_TIMEOUT) begin
            @(negedge clkin);
            n++;
        end
        if (wb_rsp.ack === 1'b1) begin
            acked = 1'b1;
            rdata = wb_rsp.dat;
        end
        @(posedge clkin);    // Write lands on this edge
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic wait_irq(input irq_vec_t want);
        int n;
        n = 0;
        @(negedge clkin);
        while (irq !== want && n < IRQ_TIMEOUT) begin
            @(negedge clkin);
            n++;
        end
        if (irq !== want) begin
            $display("Timed out waiting for irq_o to become %b, it is %b", want, irq);
            abort_run();
        end
    endtask

    task automatic wr_entry(input word_t adr, input word_t dat, input byte_en_t sel);
        entry_t e;
        e     = '0;
        e.op  = OP_WRITE;
        e.adr = adr;
        e.dat = dat;
        e.sel = sel;
        tbl.push_back(e);
    endtask

    task automatic rd_entry(input op_e op, input word_t adr, input word_t exp);
        entry_t e;
        e     = '0;
        e.op  = op;
        e.adr = adr;
        e.sel = 4'hF;
        e.exp = exp;
        tbl.push_back(e);
    endtask

    task automatic idle_entry(input int cycles, input irq_vec_t irq_exp, input logic strb_exp);
        entry_t e;
        e      = '0;
        e.op   = OP_IDLE;
        e.dat  = word_t'(cycles);
        e.irq  = irq_exp;
        e.strb = strb_exp;
        tbl.push_back(e);
    endtask

    task automatic irq_wait_entry(input irq_vec_t irq_exp);
        entry_t e;
        e     = '0;
        e.op  = OP_WAIT_IRQ;
        e.irq = irq_exp;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        word_t    d;
        word_t    model;
        byte_en_t sel;
        lfsr_q = 16'd52;
        // Reset state
        for (int t = 0; t < NUM_TIMERS; t++) begin
            rd_entry(OP_READ, reg_adr(t, CT_REG_CONFIG), '0);
            rd_entry(OP_READ, reg_adr(t, CT_REG_VALUE), '0);
            rd_entry(OP_READ, reg_adr(t, CT_REG_DATA), '0);
        end
        idle_entry(0, 2'b00, 1'b0);
        // Byte lanes on reload and config
        for (int t = 0; t < NUM_TIMERS; t++) begin
            model = '0;
            for (int k = 0; k < 6; k++) begin
                sel = 4'hF;
                if (k != 0) begin
                    random_bits(4, d);
                    sel = byte_en_t'(d[3:0]);
                end
                random_bits(32, d);
                model = byte_merge(model, d, sel);
                wr_entry(reg_adr(t, CT_REG_VALUE), d, sel);
                rd_entry(OP_READ, reg_adr(t, CT_REG_VALUE), model);
            end
            random_bits(32, d);
            d = d & ~32'h1;    // Stays disabled
            wr_entry(reg_adr(t, CT_REG_CONFIG), d, 4'hE);
            rd_entry(OP_READ, reg_adr(t, CT_REG_CONFIG), '0);
            wr_entry(reg_adr(t, CT_REG_CONFIG), d, 4'h1);
            rd_entry(OP_READ, reg_adr(t, CT_REG_CONFIG), d & 32'h1F);
            wr_entry(reg_adr(t, CT_REG_CONFIG), '0, 4'hF);
            rd_entry(OP_READ, reg_adr(t, CT_REG_CONFIG), '0);
        end
        // Oneshot down count on timer 0
        wr_entry(reg_adr(0, CT_REG_VALUE), 32'd5, 4'hF);
        wr_entry(reg_adr(0, CT_REG_CONFIG), cfg_word(1, 0, 0, 1, 1), 4'h1);
        irq_wait_entry(2'b01);
        rd_entry(OP_READ, reg_adr(0, CT_REG_DATA), '0);
        idle_entry(4, 2'b01, 1'b0);
        rd_entry(OP_READ, reg_adr(0, CT_REG_DATA), '0);
        idle_entry(0, 2'b01, 1'b0);
        wr_entry(reg_adr(0, CT_REG_CONFIG), cfg_word(1, 0, 0, 1, 0), 4'h1);
        idle_entry(1, 2'b00, 1'b0);
        rd_entry(OP_READ, reg_adr(0, CT_REG_DATA), '0);
        // Continuous up count, irq masked
        wr_entry(reg_adr(0, CT_REG_VALUE), 32'd20, 4'hF);
        wr_entry(reg_adr(0, CT_REG_CONFIG), cfg_word(0, 0, 1, 0, 1), 4'h1);
        for (int k = 0; k < 8; k++) begin
            rd_entry(OP_READ_MAX, reg_adr(0, CT_REG_DATA), 32'd20);
            idle_entry(k + 3, 2'b00, 1'b0);
        end
        for (int k = 0; k < 22; k++) begin
            idle_entry(0, 2'b00, 1'b0);    // Spans a whole wrap period
        end
        wr_entry(reg_adr(0, CT_REG_CONFIG), cfg_word(0, 0, 1, 0, 0), 4'h1);
        wr_entry(reg_adr(0, CT_REG_DATA), 32'h1234_5678, 4'hF);
        rd_entry(OP_READ, reg_adr(0, CT_REG_DATA), 32'h1234_5678);
        wr_entry(reg_adr(0, CT_REG_DATA), 32'h0000_00AB, 4'h1);
        rd_entry(OP_READ, reg_adr(0, CT_REG_DATA), 32'h1234_56AB);
        // Timer 1 counts timer 0 wraps
        wr_entry(reg_adr(1, CT_REG_VALUE), 32'd3, 4'hF);
        wr_entry(reg_adr(1, CT_REG_CONFIG), cfg_word(1, 1, 0, 1, 1), 4'h1);
        rd_entry(OP_READ, reg_adr(1, CT_REG_DATA), 32'd3);
        idle_entry(6, 2'b00, 1'b0);
        rd_entry(OP_READ, reg_adr(1, CT_REG_DATA), 32'd3);
        wr_entry(reg_adr(0, CT_REG_VALUE), 32'd2, 4'hF);
        wr_entry(reg_adr(0, CT_REG_CONFIG), cfg_word(0, 0, 0, 0, 1), 4'h1);
        irq_wait_entry(2'b10);
        idle_entry(0, 2'b10, 1'b1);
        rd_entry(OP_READ, reg_adr(1, CT_REG_DATA), '0);
        // Holes in the map
        rd_entry(OP_NOACK, reg_adr(0, 8'h0C), '0);
        rd_entry(OP_NOACK, reg_adr(1, 8'h10), '0);
        rd_entry(OP_NOACK, CT_BASE_ADR + 32'h200, '0);
        rd_entry(OP_NOACK, 32'h2500_0000, '0);
        rd_entry(OP_NOACK, 32'h0000_0004, '0);
    endtask

    task automatic apply_entry(input entry_t e);
        word_t rd;
        logic  acked;
        case (e.op)
            OP_WRITE, OP_READ, OP_READ_MAX: begin
                bus_cycle(e.op == OP_WRITE, e.adr, e.dat, e.sel, rd, acked);
                if (!acked) begin
                    $display("Bus cycle to address %h was never acknowledged", e.adr);
                    abort_run();
                end
                if (e.op == OP_READ) begin
                    check_word($sformatf("wb_rsp_o.dat[%h]", e.adr), e.exp, rd);
                end else if (e.op == OP_READ_MAX) begin
                    check_word_max($sformatf("wb_rsp_o.dat[%h]", e.adr), e.exp, rd);
                end
            end
            OP_NOACK: begin
                bus_cycle(1'b0, e.adr, '0, e.sel, rd, acked);
                check_bit($sformatf("wb_rsp_o.ack[%h]", e.adr), 1'b0, acked);
            end
            OP_IDLE: begin
                repeat (e.dat) @(posedge clkin);
                @(negedge clkin);
                check_irq("irq_o", e.irq, irq);
                check_bit("strobe_o", e.strb, strobe);
            end
            OP_WAIT_IRQ: begin
                wait_irq(e.irq);
            end
            default: begin
                $display("Table entry has an unknown operation");
                abort_run();
            end
        endcase
    endtask

    initial begin
        wb_req     = '0;
        ext_strobe = 1'b0;
        resetn     = 1'b0;
        build_table();
        repeat (4) @(posedge clkin);
        resetn <= 1'b1;
        foreach (tbl[i]) begin
            apply_entry(tbl[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
